/* all.f */
hw/exu_pkg.sv
hw/exu_ifs.sv
hw/exu_axil_front.sv
hw/exu_alu.sv
hw/exu_result_regs.sv
hw/exu_top.sv
verif/exu_assertions.sv
verif/exu_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module exu_tb -f all.f -o exu_sim
./obj_dir/exu_sim | tee sim.log
grep -q "^=== PASS ===$" sim.log
echo "Simulation passed"

/* verif/exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
    import exu_pkg::*;

    localparam int ADDR_W       = 6;
    localparam int RESET_CYCLES = 4;
    localparam int HS_LIMIT     = 16;  // Cycles allowed for one handshake.

    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] target;
        logic [DATA_W-1:0] cmd;
        logic [DATA_W-1:0] result;
        logic [DATA_W-1:0] naddr;
        logic              flag;
        logic              addrch;
    } row_t;

    logic              clock;
    logic              rst_n;
    logic [ADDR_W-1:0] s_awaddr;
    logic [ADDR_W-1:0] s_araddr;
    logic [DATA_W-1:0] s_wdata;
    logic [DATA_W-1:0] s_rdata;
    logic [3:0]        s_wstrb;
    logic [1:0]        s_bresp;
    logic [1:0]        s_rresp;
    logic              s_awvalid, s_awready, s_wvalid, s_wready;
    logic              s_bvalid, s_bready, s_arvalid, s_arready;
    logic              s_rvalid, s_rready;

    row_t              rows[$];
    logic [DATA_W-1:0] m_result;  // Running model of the result registers.
    logic [DATA_W-1:0] m_naddr;
    logic              m_flag;
    logic              m_addrch;
    logic [DATA_W-1:0] got;
    logic              table_ready = 1'b0;
    int                seed        = 11244;
    int                cur_row     = -1;
    int                mismatches  = 0;
    int                proto_errs  = 0;

    exu_top #(.ADDR_W(ADDR_W)) dut0 (.*);

    bind exu_top exu_assertions u_checks (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp, got_w);
        if (got_w !== exp)
        begin
            $display("FAILED %s (row %0d): expected 0x%h, got 0x%h", name, cur_row, exp, got_w);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, got_b);
        if (got_b !== exp)
        begin
            $display("FAILED %s (row %0d): expected 0x%h, got 0x%h", name, cur_row, exp, got_b);
            mismatches++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, got_r);
        if (got_r !== exp)
        begin
            $display("FAILED %s (row %0d): expected 0x%h, got 0x%h", name, cur_row, exp, got_r);
            mismatches++;
        end
    endtask

    function automatic logic handshake_seen(input int ch);
        case (ch)
            0:       return s_awready && s_wready;
            1:       return s_bvalid;
            2:       return s_arready;
            default: return s_rvalid;
        endcase
    endfunction

    task automatic await(input int ch, input string what);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!handshake_seen(ch) && waited < HS_LIMIT)
        begin
            waited++;
            @(negedge clock);
        end
        if (!handshake_seen(ch))
        begin
            $display("Timeout in row %0d: %s did not come within %0d cycles",
                     cur_row, what, HS_LIMIT);
            proto_errs++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic random_stall();
        int stall;
        stall = $unsigned($random(seed)) % 4;
        repeat (stall) next_cycle();
    endtask

    task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        await(0, "write address and data acceptance");
        next_cycle();
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        random_stall();  // Response must wait with bready low.
        s_bready = 1'b1;
        await(1, "write response");
        check_resp("bresp", 2'b00, s_bresp);
        next_cycle();
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        await(2, "read address acceptance");
        next_cycle();
        s_arvalid = 1'b0;
        random_stall();
        s_rready = 1'b1;
        await(3, "read data");
        data = s_rdata;
        check_resp("rresp", 2'b00, s_rresp);
        next_cycle();
        s_rready = 1'b0;
    endtask

    function automatic logic [DATA_W-1:0] flag_cmd(input exu_op_e op, input logic f1, f2);
        return {26'd0, f2, f1, op};
    endfunction

    function automatic logic [DATA_W-1:0] imm_cmd(input exu_op_e op, input logic hl,
                                                  input logic [15:0] imm);
        return {imm, 11'd0, hl, op};
    endfunction

    task automatic add_row(input logic [DATA_W-1:0] a, b, target, cmd);
        row_t        r;
        logic [4:0]  s;
        logic [15:0] imm;
        s   = b[4:0];
        imm = cmd[31:16];
        case (exu_op_e'(cmd[3:0]))
            OP_ADD:        m_result = a + b;
            OP_SUB:        m_result = a + ~b + 32'd1;
            OP_SHL:        m_result = (a << s) | ((32'd1 << s) - 32'd1);
            OP_SHR:        m_result = (a >> s) | ~(32'hFFFF_FFFF >> s);
            OP_PASS_A:     m_result = a;
            OP_PASS_B:     m_result = b;
            OP_LOAD_HALF:  m_result = cmd[4] ? {imm, a[15:0]} : {a[31:16], imm};
            OP_EQ:         m_flag = (a == b);
            OP_LT:         m_flag = (a < b);
            OP_GT:         m_flag = (a > b);
            OP_NOT_F1:     m_flag = !cmd[4];
            OP_AND_F:      m_flag = cmd[4] && cmd[5];
            OP_COPY_F1:    m_flag = cmd[4];
            OP_JUMP:
            begin
                m_addrch = 1'b1;
                m_naddr  = target;
            end
            OP_JUMP_IF_F1:
            begin
                m_addrch = cmd[4];
                m_naddr  = cmd[4] ? target : '0;
            end
            default: ;
        endcase
        r = {a, b, target, cmd, m_result, m_naddr, m_flag, m_addrch};
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        m_result = '0;  // Registers come out of reset at zero.
        m_naddr  = '0;
        m_flag   = 1'b0;
        m_addrch = 1'b0;
        add_row(32'hFFFF_FFFF, 32'h0000_0002, '0, flag_cmd(OP_ADD, 1'b0, 1'b0));
        add_row(32'h8000_0000, 32'h8000_0002, '0, flag_cmd(OP_ADD, 1'b0, 1'b0));
        add_row(32'h0000_0000, 32'h0000_0001, '0, flag_cmd(OP_SUB, 1'b0, 1'b0));
        for (int i = 0; i < 3; i++)
        begin
            x = $random(seed);
            y = $random(seed);
            add_row(x, y, '0, flag_cmd(OP_ADD, 1'b0, 1'b0));
            add_row(x, y, '0, flag_cmd(OP_SUB, 1'b0, 1'b0));
            add_row(x, y, '0, flag_cmd(OP_PASS_A, 1'b0, 1'b0));
            add_row(x, y, '0, flag_cmd(OP_PASS_B, 1'b0, 1'b0));
            add_row(y, x, '0, flag_cmd(OP_LT, 1'b0, 1'b0));  // Result must survive.
        end
        for (int i = 0; i < 5; i++)
        begin
            x = $random(seed);
            case (i)
                0:       y = 32'd0;
                1:       y = 32'd1;
                2:       y = 32'd31;
                3:       y = 32'hFFFF_FFE1;  // Shift of 1 with junk above bit 4.
                default: y = $random(seed);
            endcase
            add_row(x, y, '0, flag_cmd(OP_SHL, 1'b0, 1'b0));
            add_row(x, y, '0, flag_cmd(OP_SHR, 1'b0, 1'b0));
        end
        x = $random(seed);
        y = $random(seed);
        add_row(x, y, '0, imm_cmd(OP_LOAD_HALF, 1'b1, y[15:0]));
        add_row(x, y, '0, imm_cmd(OP_LOAD_HALF, 1'b0, y[31:16]));
        add_row(x, x, '0, flag_cmd(OP_EQ, 1'b0, 1'b0));
        add_row(x, x ^ 32'd1, '0, flag_cmd(OP_EQ, 1'b0, 1'b0));
        add_row(32'h8000_0000, 32'h1, '0, flag_cmd(OP_LT, 1'b0, 1'b0));
        add_row(32'h1, 32'h8000_0000, '0, flag_cmd(OP_LT, 1'b0, 1'b0));
        add_row(32'h8000_0000, 32'h1, '0, flag_cmd(OP_GT, 1'b0, 1'b0));
        add_row(x, x, '0, flag_cmd(OP_GT, 1'b0, 1'b0));
        for (int f = 0; f < 4; f++)
        begin
            add_row(x, y, '0, flag_cmd(OP_NOT_F1, f[0], f[1]));
            add_row(x, y, '0, flag_cmd(OP_AND_F, f[0], f[1]));
            add_row(x, y, '0, flag_cmd(OP_COPY_F1, f[0], f[1]));
        end
        y = $random(seed);
        add_row(x, x, y, flag_cmd(OP_JUMP, 1'b0, 1'b0));
        add_row(x, x, ~y, flag_cmd(OP_JUMP_IF_F1, 1'b1, 1'b0));
        add_row(x, x, y, flag_cmd(OP_JUMP_IF_F1, 1'b0, 1'b1));
        add_row(x, x, y, flag_cmd(OP_JUMP, 1'b0, 1'b0));
        add_row(x, y, y, flag_cmd(OP_ADD, 1'b0, 1'b0));  // Branch state must survive.
    endtask

    initial
    begin
        rst_n     = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = 4'hF;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst_n = 1'b1;
        foreach (rows[i])
        begin
            cur_row = i;
            axi_write(ADDR_W'(REG_A), rows[i].a);
            axi_write(ADDR_W'(REG_B), rows[i].b);
            axi_write(ADDR_W'(REG_TARGET), rows[i].target);
            axi_write(ADDR_W'(REG_CMD), rows[i].cmd);
            repeat (2) next_cycle();  // Issue and result stages.
            axi_read(ADDR_W'(REG_RESULT), got);
            check_word("result", rows[i].result, got);
            axi_read(ADDR_W'(REG_STATUS), got);
            check_bit("flag", rows[i].flag, got[0]);
            check_bit("addrch", rows[i].addrch, got[1]);
            axi_read(ADDR_W'(REG_NADDR), got);
            check_word("naddr", rows[i].naddr, got);
        end
        cur_row = rows.size();
        axi_read(6'h1C, got);
        check_word("unmapped read", '0, got);
        $display("Done: %0d rows, %0d value errors, %0d protocol errors",
                 rows.size(), mismatches, proto_errs);
        if (mismatches == 0 && proto_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        repeat (rows.size() * 40 + RESET_CYCLES + 40) @(posedge clock);
        $display("Watchdog: the run did not finish in the expected time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/exu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_assertions (
    input logic                       clock,
    input logic                       rst_n,
    input logic                       s_awvalid,
    input logic                       s_awready,
    input logic                       s_wvalid,
    input logic                       s_wready,
    input logic                       s_bvalid,
    input logic                       s_bready,
    input logic                       s_arvalid,
    input logic                       s_arready,
    input logic                       s_rvalid,
    input logic                       s_rready,
    input logic [exu_pkg::DATA_W-1:0] s_rdata
);

    a_aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
        s_awvalid && !s_awready |=> s_awvalid) else $error("AWVALID dropped before AWREADY");
    a_w_hold: assert property (@(posedge clock) disable iff (!rst_n)
        s_wvalid && !s_wready |=> s_wvalid) else $error("WVALID dropped before WREADY");
    a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        s_arvalid && !s_arready |=> s_arvalid) else $error("ARVALID dropped before ARREADY");
    a_b_hold: assert property (@(posedge clock) disable iff (!rst_n)
        s_bvalid && !s_bready |=> s_bvalid) else $error("BVALID dropped before BREADY");
    a_r_hold: assert property (@(posedge clock) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
        else $error("Read data changed or RVALID dropped before RREADY");
    // Responses are idle coming out of reset.
    a_reset: assert property (@(posedge clock) !rst_n |=> !s_bvalid && !s_rvalid)
        else $error("Response valid high after reset");

endmodule

`default_nettype wire

/* hw/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_top #(
    parameter int ADDR_W = 6
) (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [ADDR_W-1:0]            s_awaddr,
    input  logic                         s_awvalid,
    output logic                         s_awready,
    input  logic [exu_pkg::DATA_W-1:0]   s_wdata,
    input  logic [exu_pkg::DATA_W/8-1:0] s_wstrb,
    input  logic                         s_wvalid,
    output logic                         s_wready,
    output logic [1:0]                   s_bresp,
    output logic                         s_bvalid,
    input  logic                         s_bready,
    input  logic [ADDR_W-1:0]            s_araddr,
    input  logic                         s_arvalid,
    output logic                         s_arready,
    output logic [exu_pkg::DATA_W-1:0]   s_rdata,
    output logic [1:0]                   s_rresp,
    output logic                         s_rvalid,
    input  logic                         s_rready
);

    exu_issue_if  issue_bus ();
    exu_result_if result_bus ();

    exu_axil_front #(
        .ADDR_W (ADDR_W)
    ) u_front (
        .clock   (clock),
        .rst_n   (rst_n),
        .awaddr  (s_awaddr),
        .awvalid (s_awvalid),
        .awready (s_awready),
        .wdata   (s_wdata),
        .wstrb   (s_wstrb),
        .wvalid  (s_wvalid),
        .wready  (s_wready),
        .bvalid  (s_bvalid),
        .bresp   (s_bresp),
        .bready  (s_bready),
        .issue   (issue_bus.src)
    );

    exu_alu u_alu (
        .clock (clock),
        .rst_n (rst_n),
        .issue (issue_bus.dst),
        .res   (result_bus.src)
    );

    exu_result_regs #(
        .ADDR_W (ADDR_W)
    ) u_regs (
        .clock   (clock),
        .rst_n   (rst_n),
        .araddr  (s_araddr),
        .arvalid (s_arvalid),
        .arready (s_arready),
        .rdata   (s_rdata),
        .rresp   (s_rresp),
        .rvalid  (s_rvalid),
        .rready  (s_rready),
        .res     (result_bus.dst)
    );

endmodule

`default_nettype wire

/* hw/exu_result_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_result_regs #(
    parameter int ADDR_W = 6
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic [ADDR_W-1:0]          araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [exu_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    exu_result_if.dst                  res
);
    import exu_pkg::*;

    logic [DATA_W-1:0] result_q;
    logic [DATA_W-1:0] naddr_q;
    logic              flag_q;
    logic              addrch_q;

    assign arready = !rvalid;
    assign rresp   = 2'b00;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            result_q <= '0;
            naddr_q  <= '0;
            flag_q   <= 1'b0;
            addrch_q <= 1'b0;
            rvalid   <= 1'b0;
        end
        else
        begin
            if (res.valid && res.we_result)
                result_q <= res.data.result;
            if (res.valid && res.we_flag)
                flag_q <= res.data.flag;
            if (res.valid && res.we_naddr)
            begin
                naddr_q  <= res.data.naddr;
                addrch_q <= res.data.addrch;
            end

            if (arvalid && arready)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end

        if (arvalid && arready)
        begin
            case (araddr)
                ADDR_W'(REG_RESULT): rdata <= result_q;
                ADDR_W'(REG_STATUS): rdata <= {{(DATA_W-2){1'b0}}, addrch_q, flag_q};
                ADDR_W'(REG_NADDR):  rdata <= naddr_q;
                default:             rdata <= '0;  // Unmapped reads as zero.
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/exu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    input  logic      clock,
    input  logic      rst_n,
    exu_issue_if.dst  issue,
    exu_result_if.src res
);
    import exu_pkg::*;

    exu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [4:0]        shamt;
    logic              f1;
    logic              f2;
    exu_result_s       nxt;
    logic              nxt_we_result;
    logic              nxt_we_flag;
    logic              nxt_we_naddr;

    assign op    = issue.cmd.flg.op;
    assign a     = issue.a;
    assign b     = issue.b;
    assign shamt = b[4:0];  // Upper bits of B are ignored.
    assign f1    = issue.cmd.flg.f1;
    assign f2    = issue.cmd.flg.f2;

    always_comb
    begin
        nxt           = '0;
        nxt_we_result = 1'b0;
        nxt_we_flag   = 1'b0;
        nxt_we_naddr  = 1'b0;
        case (op)
            OP_ADD,
            OP_SUB,
            OP_SHL,
            OP_SHR,
            OP_PASS_A,
            OP_LOAD_HALF,
            OP_PASS_B: nxt_we_result = 1'b1;
            OP_EQ,
            OP_LT,
            OP_GT,
            OP_NOT_F1,
            OP_AND_F,
            OP_COPY_F1: nxt_we_flag = 1'b1;
            OP_JUMP,
            OP_JUMP_IF_F1: nxt_we_naddr = 1'b1;
            default: ;  // NOP leaves every register alone.
        endcase

        case (op)
            OP_ADD:       nxt.result = a + b;
            OP_SUB:       nxt.result = a - b;
            OP_SHL:       nxt.result = ~((~a) << shamt);  // Fill with ones.
            OP_SHR:       nxt.result = ~((~a) >> shamt);
            OP_PASS_A:    nxt.result = a;
            OP_PASS_B:    nxt.result = b;
            OP_LOAD_HALF:
            begin
                if (issue.cmd.imm.highlow)
                    nxt.result = {issue.cmd.imm.imm16, a[15:0]};
                else
                    nxt.result = {a[31:16], issue.cmd.imm.imm16};
            end
            OP_EQ:        nxt.flag = (a == b);
            OP_LT:        nxt.flag = (a < b);
            OP_GT:        nxt.flag = (a > b);
            OP_NOT_F1:    nxt.flag = ~f1;
            OP_AND_F:     nxt.flag = f1 & f2;
            OP_COPY_F1:   nxt.flag = f1;
            OP_JUMP:
            begin
                nxt.naddr  = issue.target;
                nxt.addrch = 1'b1;
            end
            OP_JUMP_IF_F1:
            begin
                nxt.naddr  = issue.target & {DATA_W{f1}};  // Masked target.
                nxt.addrch = f1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            res.valid     <= 1'b0;
            res.we_result <= 1'b0;
            res.we_flag   <= 1'b0;
            res.we_naddr  <= 1'b0;
        end
        else
        begin
            res.valid     <= issue.valid;
            res.we_result <= nxt_we_result;  // Qualified by valid downstream.
            res.we_flag   <= nxt_we_flag;
            res.we_naddr  <= nxt_we_naddr;
        end
        if (issue.valid)
            res.data <= nxt;
    end

endmodule

`default_nettype wire

/* hw/exu_axil_front.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_axil_front #(
    parameter int ADDR_W = 6
) (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [ADDR_W-1:0]            awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [exu_pkg::DATA_W-1:0]   wdata,
    input  logic [exu_pkg::DATA_W/8-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic                         bvalid,
    output logic [1:0]                   bresp,
    input  logic                         bready,
    exu_issue_if.src                     issue
);
    import exu_pkg::*;

    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] b_q;
    logic [DATA_W-1:0] target_q;
    exu_cmd_u          cmd_q;
    logic              issue_valid_q;
    logic              wr_fire;

    function automatic logic [DATA_W-1:0] merge_strb(
        input logic [DATA_W-1:0]   old_w,
        input logic [DATA_W-1:0]   new_w,
        input logic [DATA_W/8-1:0] strb
    );
        logic [DATA_W-1:0] merged;
        merged = old_w;
        for (int i = 0; i < DATA_W/8; i++)
        begin
            if (strb[i])
            begin
                merged[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    // AW and W are taken together as one beat.
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wvalid && !bvalid;
    assign wready  = awvalid && !bvalid;
    assign bresp   = 2'b00;  // Always OKAY.

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            a_q           <= '0;
            b_q           <= '0;
            target_q      <= '0;
            cmd_q         <= '0;
            issue_valid_q <= 1'b0;
            bvalid        <= 1'b0;
        end
        else
        begin
            issue_valid_q <= 1'b0;
            if (wr_fire)
            begin
                bvalid <= 1'b1;
                case (awaddr)
                    ADDR_W'(REG_A):      a_q      <= merge_strb(a_q, wdata, wstrb);
                    ADDR_W'(REG_B):      b_q      <= merge_strb(b_q, wdata, wstrb);
                    ADDR_W'(REG_TARGET): target_q <= merge_strb(target_q, wdata, wstrb);
                    ADDR_W'(REG_CMD):
                    begin
                        cmd_q         <= merge_strb(cmd_q, wdata, wstrb);
                        issue_valid_q <= 1'b1;  // Rises with bvalid.
                    end
                    default: ;  // Unmapped writes are dropped.
                endcase
            end
            else if (bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    assign issue.a      = a_q;
    assign issue.b      = b_q;
    assign issue.target = target_q;
    assign issue.cmd    = cmd_q;
    assign issue.valid  = issue_valid_q;

endmodule

`default_nettype wire

/* hw/exu_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

interface exu_issue_if;
    import exu_pkg::*;

    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] target;
    exu_cmd_u          cmd;
    logic              valid;  // One-cycle pulse, always accepted.

    modport src (output a, b, target, cmd, valid);
    modport dst (input a, b, target, cmd, valid);
endinterface

interface exu_result_if;
    import exu_pkg::*;

    exu_result_s data;
    logic        valid;
    logic        we_result;
    logic        we_flag;
    logic        we_naddr;  // Covers naddr and addrch.

    modport src (output data, valid, we_result, we_flag, we_naddr);
    modport dst (input data, valid, we_result, we_flag, we_naddr);
endinterface

`default_nettype wire

/* hw/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    localparam int DATA_W = 32;  // Fixed by the command word layout.

    typedef enum logic [3:0] {
        OP_ADD        = 4'd0,
        OP_SUB        = 4'd1,
        OP_SHL        = 4'd2,
        OP_SHR        = 4'd3,
        OP_PASS_A     = 4'd4,
        OP_LOAD_HALF  = 4'd5,
        OP_PASS_B     = 4'd6,
        OP_NOP        = 4'd7,
        OP_EQ         = 4'd8,
        OP_LT         = 4'd9,
        OP_GT         = 4'd10,
        OP_NOT_F1     = 4'd11,
        OP_AND_F      = 4'd12,
        OP_COPY_F1    = 4'd13,
        OP_JUMP       = 4'd14,
        OP_JUMP_IF_F1 = 4'd15
    } exu_op_e;

    typedef struct packed {
        logic [25:0] rsvd;
        logic        f2;
        logic        f1;
        exu_op_e     op;
    } exu_cmd_flag_s;

    typedef struct packed {
        logic [15:0] imm16;
        logic [10:0] rsvd;
        logic        highlow;  // 1 loads the upper half.
        exu_op_e     op;
    } exu_cmd_imm_s;

    typedef union packed {
        exu_cmd_flag_s flg;
        exu_cmd_imm_s  imm;
    } exu_cmd_u;

    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic [DATA_W-1:0] naddr;
        logic              flag;
        logic              addrch;
    } exu_result_s;

    // Write-only registers.
    localparam logic [5:0] REG_A      = 6'h00;
    localparam logic [5:0] REG_B      = 6'h04;
    localparam logic [5:0] REG_TARGET = 6'h08;
    localparam logic [5:0] REG_CMD    = 6'h0C;
    // Read-only registers.
    localparam logic [5:0] REG_RESULT = 6'h10;
    localparam logic [5:0] REG_STATUS = 6'h14;
    localparam logic [5:0] REG_NADDR  = 6'h18;

endpackage

`default_nettype wire
